/* all.f */
+incdir+design
design/memL1Pkg.sv
design/memIcache.sv
design/memDcache.sv
design/memL1Arbiter.sv
design/memL1.sv
test/memL1_checker.sv
test/memL1Tb.sv

/* test/memL1Tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memL1_cfg.svh"

module memL1Tb
	import memL1Pkg::*;
();

	localparam int WAIT_LIMIT = 64;	// cycles per wait

	typedef struct
	{
		bit				isData;		// 0 fetch port, 1 data port
		dcOpm			op;
		logic [31:0]	addr;
		logic [31:0]	wdata;
		logic [31:0]	expVal;
		memOk			expOk;
		excWord			expExc;
		bit				mustHit;	// result in the first cycle
	} stimRow;

	logic						clock;
	logic						reset;
	logic [31:0]				pcAddr;
	logic						pcHold;
	logic [31:0]				pcVal;
	memOk						pcOk;
	logic [31:0]				dcAddr;
	dcOpm						dataOp;
	logic [31:0]				dcInVal;
	logic						dcHold;
	logic [31:0]				dcOutVal;
	memOk						dcOk;
	logic						dcOutHold;
	logic [31:0]				busAddr;
	memOpm						busOpm;
	logic [`L1_LINE_BITS-1:0]	busDataOut;
	memOk						busOk;
	logic [`L1_LINE_BITS-1:0]	busDataIn;
	excWord						regOutExc;

	logic [31:0]	memWords [logic [31:0]];	// sparse, only stored words
	integer			seed;
	int				busCount;	// transactions started
	stimRow			rows [$];

	memL1 dut_i (
		.clock(clock), .reset(reset),
		.pcAddr(pcAddr), .pcHold(pcHold), .pcVal(pcVal), .pcOk(pcOk),
		.dcAddr(dcAddr), .dcOpm(dataOp), .dcInVal(dcInVal), .dcHold(dcHold),
		.dcOutVal(dcOutVal), .dcOk(dcOk), .dcOutHold(dcOutHold),
		.memAddr(busAddr), .memOpm(busOpm), .memDataOut(busDataOut),
		.memOk(busOk), .memDataIn(busDataIn), .regOutExc(regOutExc)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] patternWord(input logic [31:0] a);
		return {a[31:2], 2'b00} ^ 32'hA5A50000;
	endfunction

	function automatic logic [31:0] readWord(input logic [31:0] a);
		logic [31:0] w;
		w = {a[31:2], 2'b00};
		if (memWords.exists(w))
			return memWords[w];
		return patternWord(w);
	endfunction

	function automatic excWord makeExc(input logic [31:0] a, input logic [15:0] code);
		excWord e;
		e = '0;
		e.addr = a;
		e.code = code;
		return e;
	endfunction

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkMemOk(input string name, input memOk exp, input memOk act);
		if (act !== exp)
			failRun($sformatf("Mismatch at %0t: %s expected %0d, got %0d",
				$time, name, exp, act));
	endtask

	task automatic checkWord(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
			failRun($sformatf("Mismatch at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
			failRun($sformatf("Mismatch at %0t: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	task automatic checkExc(input string name, input excWord exp, input excWord act);
		if (act !== exp)
			failRun($sformatf("Mismatch at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	// memory model, samples the bus at the edge and answers 1 ns later
	initial
	begin
		int						state;	// 0 idle, 1 busy, 2 result cycle
		int						lat;
		logic [31:0]			a;
		logic [15:0]			code;
		logic [`L1_LINE_BITS-1:0]	line;
		state = 0;
		lat = 0;
		forever
		begin
			@(posedge clock);
			a = busAddr;
			if (reset)
				state = 0;
			else if (state == 0 && busOpm != OPM_READY)
			begin
				state = 1;
				busCount++;
				lat = ($unsigned($random(seed)) % 4) + 1;	// HOLD cycles
			end
			else if (state == 1 && lat > 1)
				lat--;
			else if (state == 1)
				state = 2;
			else if (state == 2)
				state = 0;
			#1;
			busDataIn = '0;
			busOk = (state == 1) ? OK_HOLD : OK_READY;
			if (state == 2)
			begin
				code = 16'h0000;
				if (a >= 32'hF0000000)
					code = 16'h8000 + a[7:0];	// critical
				else if (a >= 32'hE0000000)
					code = 16'h0005;
				if (code != 16'h0000)
				begin
					busOk = OK_FAULT;
					busDataIn[15:0] = code;
				end
				else
				begin
					busOk = OK_OK;
					if (busOpm == OPM_STOREWORD)
						memWords[{a[31:2], 2'b00}] = busDataOut[31:0];
					else
					begin
						for (int i = 0; i < 4; i++)
							line[i*32 +: 32] = readWord({a[31:4], 4'h0} + 4*i);
						busDataIn = line;
					end
				end
			end
		end
	end

	task automatic addRow(input bit isData, input dcOpm op, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [31:0] expVal, input memOk expOk,
		input excWord expExc, input bit mustHit);
		stimRow r;
		r.isData = isData;
		r.op = op;
		r.addr = addr;
		r.wdata = wdata;
		r.expVal = expVal;
		r.expOk = expOk;
		r.expExc = expExc;
		r.mustHit = mustHit;
		rows.push_back(r);
	endtask

	// first non-HOLD cycle after the request was registered
	task automatic waitResult(input bit isData, input logic firstHold, output int cycles);
		memOk st;
		cycles = 0;
		st = OK_HOLD;
		while (st == OK_HOLD)
		begin
			@(negedge clock);
			cycles++;
			st = isData ? dcOk : pcOk;
			if (isData && cycles == 1)
				checkFlag("dcOutHold", firstHold, dcOutHold);	// stall from the first cycle
			if (cycles > WAIT_LIMIT)
				failRun(isData ? "data port stuck in HOLD" : "fetch port stuck in HOLD");
		end
		if (isData)
			checkFlag("dcOutHold", 1'b0, dcOutHold);
	endtask

	task automatic applyRow(input stimRow r);
		int cycles;
		int busBefore;
		logic firstHold;
		busBefore = busCount;
		firstHold = r.isData && !r.mustHit && (r.addr[1:0] == 2'b00);	// goes to the bus
		@(posedge clock);
		#1;
		if (r.isData)
		begin
			dcAddr = r.addr;
			dataOp = r.op;
			dcInVal = r.wdata;
			dcHold = 1'b0;
		end
		else
		begin
			pcAddr = r.addr;
			pcHold = 1'b0;
		end
		@(posedge clock);	// request registered here
		#1;
		pcHold = 1'b1;
		dcHold = 1'b1;
		dataOp = DC_NONE;
		waitResult(r.isData, firstHold, cycles);
		if (r.mustHit)
			checkWord("hit latency", 32'd1, cycles);
		checkMemOk(r.isData ? "dcOk" : "pcOk", r.expOk, r.isData ? dcOk : pcOk);
		if (r.expOk == OK_OK && r.op != DC_STORE)
			checkWord(r.isData ? "dcOutVal" : "pcVal", r.expVal,
				r.isData ? dcOutVal : pcVal);
		if (r.isData && r.op == DC_STORE)
			checkWord("memory word", r.wdata, readWord(r.addr));
		@(negedge clock);	// exception word one cycle later
		checkExc("regOutExc", r.expExc, regOutExc);
		if (r.isData && r.addr[1:0] != 2'b00)
			checkWord("bus requests", busBefore, busCount);	// misalign stays off the bus
	endtask

	// instruction and data miss issued in the same cycle
	task automatic concurrentMiss(input logic [31:0] iAddr, input logic [31:0] dAddr);
		int cycles;
		int icDone;
		int dcDone;
		icDone = 0;
		dcDone = 0;
		cycles = 0;
		@(posedge clock);
		#1;
		pcAddr = iAddr;
		pcHold = 1'b0;
		dcAddr = dAddr;
		dataOp = DC_LOAD;
		dcHold = 1'b0;
		@(posedge clock);
		#1;
		pcHold = 1'b1;
		dcHold = 1'b1;
		dataOp = DC_NONE;
		while (icDone == 0 || dcDone == 0)
		begin
			@(negedge clock);
			cycles++;
			if (icDone == 0 && pcOk != OK_HOLD)
				icDone = cycles;
			if (dcDone == 0 && dcOk != OK_HOLD)
				dcDone = cycles;
			if (cycles > WAIT_LIMIT)
				failRun("concurrent misses never completed");
		end
		checkMemOk("pcOk", OK_OK, pcOk);
		checkMemOk("dcOk", OK_OK, dcOk);
		checkWord("pcVal", patternWord(iAddr), pcVal);
		checkWord("dcOutVal", patternWord(dAddr), dcOutVal);
		if (icDone >= dcDone)
			failRun("instruction miss did not finish before the data miss");
	endtask

	initial
	begin
		seed = 21216;
		busCount = 0;
		reset = 1'b1;
		pcAddr = '0;
		pcHold = 1'b1;
		dcAddr = '0;
		dataOp = DC_NONE;
		dcInVal = '0;
		dcHold = 1'b1;
		busOk = OK_READY;
		busDataIn = '0;

		addRow(0, DC_NONE, 32'h00001008, 0, patternWord(32'h00001008), OK_OK, '0, 0);
		addRow(0, DC_NONE, 32'h0000100C, 0, patternWord(32'h0000100C), OK_OK, '0, 1);
		addRow(1, DC_STORE, 32'h00002004, 32'hDEADBEEF, 0, OK_OK, '0, 0);
		addRow(1, DC_LOAD, 32'h00002004, 0, 32'hDEADBEEF, OK_OK, '0, 0);
		addRow(1, DC_LOAD, 32'h00002008, 0, patternWord(32'h00002008), OK_OK, '0, 1);
		addRow(1, DC_STORE, 32'h00002008, 32'h12345678, 0, OK_OK, '0, 0);
		addRow(1, DC_LOAD, 32'h00002008, 0, 32'h12345678, OK_OK, '0, 1);
		addRow(1, DC_LOAD, 32'hF0000010, 0, 0, OK_FAULT,
			makeExc(32'hF0000010, 16'h8010), 0);
		addRow(1, DC_LOAD, 32'hE0000020, 0, 0, OK_FAULT, '0, 0);	// soft fault
		addRow(1, DC_LOAD, 32'h00003002, 0, 0, OK_FAULT,
			makeExc(32'h00003002, `L1_EXC_MISALIGN), 0);
		addRow(0, DC_NONE, 32'hF0000024, 0, 0, OK_FAULT,
			makeExc(32'hF0000024, 16'h8024), 0);

		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
		@(negedge clock);
		checkMemOk("pcOk", OK_READY, pcOk);
		checkMemOk("dcOk", OK_READY, dcOk);
		checkExc("regOutExc", '0, regOutExc);

		foreach (rows[i])
			applyRow(rows[i]);
		concurrentMiss(32'h00004004, 32'h00005008);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/memL1_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module memL1_checker
	import memL1Pkg::*;
(
	input wire logic			clock,
	input wire logic			reset,
	input wire memOpm			busOpm,
	input wire logic [31:0]		busAddr,
	input wire memOk			busOk,
	input wire memOk			pcOk,
	input wire memOk			dcOk,
	input wire logic			dcOutHold,
	input wire logic			dcMisalign,
	input wire excWord			regOutExc
);

	// requester frozen while memory is busy
	holdStable: assert property (@(posedge clock) disable iff (reset)
		(busOk == OK_HOLD) |=> ($stable(busOpm) && $stable(busAddr)))
		else $error("bus request changed during HOLD");

	// one idle cycle after every transaction
	gapAfterDone: assert property (@(posedge clock) disable iff (reset)
		(busOk == OK_OK || busOk == OK_FAULT) |=> (busOpm == OPM_READY))
		else $error("bus opm not idle after completion");

	resetQuiet: assert property (@(posedge clock)
		$fell(reset) |-> (pcOk == OK_READY && dcOk == OK_READY && !dcOutHold &&
			busOpm == OPM_READY && regOutExc == '0))
		else $error("outputs active right after reset");

	excCause: assert property (@(posedge clock) disable iff (reset)
		(regOutExc != '0) |-> $past(busOk == OK_FAULT || dcMisalign))
		else $error("exception word without a fault");

endmodule

bind memL1 memL1_checker checker_i (
	.clock(clock), .reset(reset),
	.busOpm(memOpm), .busAddr(memAddr), .busOk(memOk),
	.pcOk(pcOk), .dcOk(dcOk), .dcOutHold(dcOutHold),
	.dcMisalign(dcMisalign), .regOutExc(regOutExc)
);

`default_nettype wire

/* design/memL1.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memL1_cfg.svh"

module memL1
	import memL1Pkg::*;
(
	input wire logic						clock,
	input wire logic						reset,

	// fetch port
	input wire logic [`L1_ADDR_BITS-1:0]	pcAddr,
	input wire logic						pcHold,
	output logic [31:0]						pcVal,
	output memL1Pkg::memOk					pcOk,

	// data port
	input wire logic [`L1_ADDR_BITS-1:0]	dcAddr,
	input wire memL1Pkg::dcOpm				dcOpm,
	input wire logic [31:0]					dcInVal,
	input wire logic						dcHold,
	output logic [31:0]						dcOutVal,
	output memL1Pkg::memOk					dcOk,
	output logic							dcOutHold,

	// memory bus
	output logic [`L1_ADDR_BITS-1:0]		memAddr,
	output memL1Pkg::memOpm					memOpm,
	output logic [`L1_LINE_BITS-1:0]		memDataOut,
	input wire memL1Pkg::memOk				memOk,
	input wire logic [`L1_LINE_BITS-1:0]	memDataIn,

	output excWord							regOutExc
);

	// icache to arbiter
	logic [`L1_ADDR_BITS-1:0]	icBusAddr;
	memL1Pkg::memOpm			icBusOpm;
	memL1Pkg::memOk				icBusOk;

	// dcache to arbiter
	logic [`L1_ADDR_BITS-1:0]	dcBusAddr;
	memL1Pkg::memOpm			dcBusOpm;
	logic [`L1_LINE_BITS-1:0]	dcBusDataOut;
	memL1Pkg::memOk				dcBusOk;
	logic						dcMisalign;

	memIcache memIc (
		.clock(clock), .reset(reset),
		.pcAddr(pcAddr), .pcHold(pcHold), .pcVal(pcVal), .pcOk(pcOk),
		.busAddr(icBusAddr), .busOpm(icBusOpm), .busOk(icBusOk),
		.busData(memDataIn)	// read data goes to both caches
	);

	memDcache memDc (
		.clock(clock), .reset(reset),
		.dcAddr(dcAddr), .dcOpm(dcOpm), .dcInVal(dcInVal), .dcHold(dcHold),
		.dcOutVal(dcOutVal), .dcOk(dcOk), .dcOutHold(dcOutHold),
		.busAddr(dcBusAddr), .busOpm(dcBusOpm), .busDataOut(dcBusDataOut),
		.busOk(dcBusOk), .busData(memDataIn), .misalign(dcMisalign)
	);

	memL1Arbiter arb (
		.clock(clock), .reset(reset),
		.icAddr(icBusAddr), .icOpm(icBusOpm), .icOk(icBusOk),
		.dcAddr(dcBusAddr), .dcOpm(dcBusOpm), .dcDataOut(dcBusDataOut),
		.dcOk(dcBusOk), .dcMisalign(dcMisalign),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memOk(memOk), .memDataIn(memDataIn),
		.regOutExc(regOutExc)
	);

endmodule

`default_nettype wire

/* design/memL1Arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memL1_cfg.svh"

module memL1Arbiter
	import memL1Pkg::*;
(
	input wire logic						clock,
	input wire logic						reset,

	// instruction cache side
	input wire logic [`L1_ADDR_BITS-1:0]	icAddr,
	input wire memL1Pkg::memOpm				icOpm,
	output memL1Pkg::memOk					icOk,

	// data cache side
	input wire logic [`L1_ADDR_BITS-1:0]	dcAddr,
	input wire memL1Pkg::memOpm				dcOpm,
	input wire logic [`L1_LINE_BITS-1:0]	dcDataOut,
	output memL1Pkg::memOk					dcOk,
	input wire logic						dcMisalign,

	// external memory bus
	output logic [`L1_ADDR_BITS-1:0]		memAddr,
	output memL1Pkg::memOpm					memOpm,
	output logic [`L1_LINE_BITS-1:0]		memDataOut,
	input wire memL1Pkg::memOk				memOk,
	input wire logic [`L1_LINE_BITS-1:0]	memDataIn,

	output excWord							regOutExc
);

	logic	latchIc;	// icache owns the bus
	logic	latchDc;
	logic	icReq;
	logic	dcReq;
	logic	icOwn;
	logic	dcOwn;
	logic	nxtLatchIc;
	logic	nxtLatchDc;
	excWord	excNext;

	assign icReq = (icOpm != OPM_READY);
	assign dcReq = (dcOpm != OPM_READY);

	// latched owner first, then icache priority
	assign icOwn = latchIc || (!latchDc && icReq);
	assign dcOwn = !icOwn && (latchDc || dcReq);

	// held until opm drops and the bus goes quiet
	assign nxtLatchIc = icOwn && (icReq || (memOk != OK_READY));
	assign nxtLatchDc = dcOwn && (dcReq || (memOk != OK_READY));

	always_comb
	begin
		memAddr		= '0;
		memOpm		= OPM_READY;
		memDataOut	= '0;
		icOk		= OK_READY;	// loser reads this as wait
		dcOk		= OK_READY;
		if (icOwn)
		begin
			memAddr	= icAddr;
			memOpm	= icOpm;
			icOk	= memOk;
		end
		else if (dcOwn)
		begin
			memAddr		= dcAddr;
			memOpm		= dcOpm;
			memDataOut	= dcDataOut;
			dcOk		= memOk;
		end
	end

	always_comb
	begin
		excNext = '0;
		// bit 15 clear means a soft failure, no exception
		if ((icOwn || dcOwn) && (memOk == OK_FAULT) && memDataIn[15])
		begin
			excNext.addr = memAddr;
			excNext.code = memDataIn[15:0];
		end
		if (dcMisalign)
		begin
			excNext.addr = dcAddr;	// full byte address
			excNext.code = `L1_EXC_MISALIGN;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			latchIc		<= 1'b0;
			latchDc		<= 1'b0;
			regOutExc	<= '0;
		end
		else
		begin
			latchIc		<= nxtLatchIc;
			latchDc		<= nxtLatchDc;
			regOutExc	<= excNext;	// zero when nothing faulted
		end
	end

endmodule

`default_nettype wire

/* design/memDcache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memL1_cfg.svh"

module memDcache
	import memL1Pkg::*;
(
	input wire logic						clock,
	input wire logic						reset,
	input wire logic [`L1_ADDR_BITS-1:0]	dcAddr,		// byte address
	input wire memL1Pkg::dcOpm				dcOpm,
	input wire logic [31:0]					dcInVal,	// store word
	input wire logic						dcHold,		// freeze input stage
	output logic [31:0]						dcOutVal,	// load word
	output memL1Pkg::memOk					dcOk,
	output logic							dcOutHold,	// pipeline stall
	output logic [`L1_ADDR_BITS-1:0]		busAddr,
	output memL1Pkg::memOpm					busOpm,
	output logic [`L1_LINE_BITS-1:0]		busDataOut,
	input wire memL1Pkg::memOk				busOk,		// masked by the arbiter
	input wire logic [`L1_LINE_BITS-1:0]	busData,
	output logic							misalign	// result cycle only
);

	localparam int IDX_BITS = $clog2(`L1_DC_LINES);
	localparam int TAG_BITS = `L1_ADDR_BITS - 4 - IDX_BITS;

	logic [TAG_BITS-1:0]		tagArr [`L1_DC_LINES];
	logic [`L1_LINE_BITS-1:0]	lineArr [`L1_DC_LINES];
	logic [`L1_DC_LINES-1:0]	validArr;

	// registered request
	logic [`L1_ADDR_BITS-1:0]	reqAddr;
	memL1Pkg::dcOpm				reqOpm;
	logic [31:0]				reqVal;
	memL1Pkg::memOk				doneSt;		// bus result kept while held
	logic						busDone;
	logic						fresh;		// first cycle of a registered request

	logic [IDX_BITS-1:0]		reqIdx;
	logic [TAG_BITS-1:0]		reqTag;
	logic						isLoad;
	logic						isStore;
	logic						misalignNow;
	logic						hit;
	logic						needBus;
	logic						reqActive;
	logic						doneOk;
	logic						doneFault;
	logic						accept;
	logic [`L1_LINE_BITS-1:0]	selLine;

	assign reqIdx = reqAddr[4 +: IDX_BITS];
	assign reqTag = reqAddr[4 + IDX_BITS +: TAG_BITS];

	assign isLoad = (reqOpm == DC_LOAD);
	assign isStore = (reqOpm == DC_STORE);
	assign misalignNow = (reqOpm != DC_NONE) && (reqAddr[1:0] != 2'b00);

	assign hit = validArr[reqIdx] && (tagArr[reqIdx] == reqTag);

	// stores always go out, loads only on miss
	assign needBus = !misalignNow && (doneSt == OK_READY) &&
		(isStore || (isLoad && !hit));
	assign reqActive = needBus && !busDone;	// gap cycle after a transaction
	assign doneOk = reqActive && (busOk == OK_OK);
	assign doneFault = reqActive && (busOk == OK_FAULT);

	assign accept = !dcHold && (!needBus || doneOk || doneFault);

	assign busAddr = reqAddr;
	assign busDataOut = {{(`L1_LINE_BITS - 32){1'b0}}, reqVal};	// word in low bits

	always_comb
	begin
		busOpm = OPM_READY;
		if (reqActive)
			busOpm = isStore ? OPM_STOREWORD : OPM_LOADLINE;
	end

	// fill bypass for loads
	assign selLine = (doneOk && isLoad) ? busData : lineArr[reqIdx];
	assign dcOutVal = selLine[reqAddr[3:2] * 32 +: 32];

	always_comb
	begin
		dcOk = OK_HOLD;
		if (reqOpm == DC_NONE)
			dcOk = OK_READY;
		else if (misalignNow)
			dcOk = OK_FAULT;	// never reaches the bus
		else if (doneSt != OK_READY)
			dcOk = doneSt;
		else if (doneOk || doneFault)
			dcOk = busOk;
		else if (isLoad && hit)
			dcOk = OK_OK;
	end

	assign dcOutHold = (dcOk == OK_HOLD);
	assign misalign = misalignNow && fresh;	// one pulse per request

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqOpm		<= DC_NONE;
			doneSt		<= OK_READY;
			busDone		<= 1'b0;
			fresh		<= 1'b0;
			validArr	<= '0;
		end
		else
		begin
			busDone <= doneOk || doneFault;
			fresh <= accept;
			if (accept)
			begin
				reqOpm	<= dcOpm;
				doneSt	<= OK_READY;
			end
			else if (doneOk || doneFault)
				doneSt <= busOk;	// stable output under dcHold
			if (doneOk && isLoad)
				validArr[reqIdx] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			reqAddr	<= dcAddr;
			reqVal	<= dcInVal;
		end
		if (doneOk && isLoad)
		begin
			tagArr[reqIdx]	<= reqTag;
			lineArr[reqIdx]	<= busData;
		end
		else if (doneOk && isStore && hit)
			lineArr[reqIdx][reqAddr[3:2] * 32 +: 32] <= reqVal;	// no allocate on miss
	end

endmodule

`default_nettype wire

/* design/memIcache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "memL1_cfg.svh"

module memIcache
	import memL1Pkg::*;
(
	input wire logic						clock,
	input wire logic						reset,
	input wire logic [`L1_ADDR_BITS-1:0]	pcAddr,		// fetch address
	input wire logic						pcHold,		// freeze input stage
	output logic [31:0]						pcVal,		// instruction word
	output memL1Pkg::memOk					pcOk,
	output logic [`L1_ADDR_BITS-1:0]		busAddr,
	output memL1Pkg::memOpm					busOpm,
	input wire memL1Pkg::memOk				busOk,		// already masked by the arbiter
	input wire logic [`L1_LINE_BITS-1:0]	busData
);

	localparam int IDX_BITS = $clog2(`L1_IC_LINES);
	localparam int TAG_BITS = `L1_ADDR_BITS - 4 - IDX_BITS;

	// storage, only valid bits get cleared
	logic [TAG_BITS-1:0]		tagArr [`L1_IC_LINES];
	logic [`L1_LINE_BITS-1:0]	lineArr [`L1_IC_LINES];
	logic [`L1_IC_LINES-1:0]	validArr;

	// registered request
	logic [`L1_ADDR_BITS-1:0]	reqAddr;
	logic						reqValid;
	logic						faultSeen;	// fill failed, keep reporting it
	logic						busDone;	// bus finished last cycle

	logic [IDX_BITS-1:0]		reqIdx;
	logic [TAG_BITS-1:0]		reqTag;
	logic						hit;
	logic						missPending;
	logic						reqActive;
	logic						doneOk;
	logic						doneFault;
	logic						accept;
	logic [`L1_LINE_BITS-1:0]	selLine;

	assign reqIdx = reqAddr[4 +: IDX_BITS];
	assign reqTag = reqAddr[4 + IDX_BITS +: TAG_BITS];

	assign hit = reqValid && validArr[reqIdx] && (tagArr[reqIdx] == reqTag);
	assign missPending = reqValid && !hit && !faultSeen;

	// opm drops for one cycle after each transaction
	assign reqActive = missPending && !busDone;
	assign doneOk = reqActive && (busOk == OK_OK);
	assign doneFault = reqActive && (busOk == OK_FAULT);

	// new address only when the current one is resolved
	assign accept = !pcHold && (!missPending || doneOk || doneFault);

	assign busAddr = reqAddr;	// memory aligns line loads
	assign busOpm = reqActive ? OPM_LOADLINE : OPM_READY;

	// bypass the returning line on the fill cycle
	assign selLine = doneOk ? busData : lineArr[reqIdx];
	assign pcVal = selLine[reqAddr[3:2] * 32 +: 32];

	always_comb
	begin
		pcOk = OK_HOLD;	// miss in flight, or loser waiting
		if (!reqValid)
			pcOk = OK_READY;
		else if (faultSeen || doneFault)
			pcOk = OK_FAULT;
		else if (hit || doneOk)
			pcOk = OK_OK;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqValid	<= 1'b0;
			faultSeen	<= 1'b0;
			busDone		<= 1'b0;
			validArr	<= '0;
		end
		else
		begin
			busDone <= doneOk || doneFault;
			if (accept)
			begin
				reqValid	<= 1'b1;
				faultSeen	<= 1'b0;
			end
			else if (doneFault)
				faultSeen <= 1'b1;	// held across pcHold
			if (doneOk)
				validArr[reqIdx] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
			reqAddr <= pcAddr;
		if (doneOk)
		begin
			tagArr[reqIdx]	<= reqTag;
			lineArr[reqIdx]	<= busData;	// no fill on fault
		end
	end

endmodule

`default_nettype wire

/* design/memL1Pkg.sv */
`default_nettype none

package memL1Pkg;

	// memory bus operation
	typedef enum logic [2:0]
	{
		OPM_READY		= 3'd0,	// idle, no request
		OPM_LOADLINE	= 3'd1,	// read one full line
		OPM_STOREWORD	= 3'd2	// write low 32 bits of data
	} memOpm;

	// status level, shared by the bus and the cache result ports
	typedef enum logic [1:0]
	{
		OK_READY	= 2'd0,	// nothing pending, or not granted
		OK_OK		= 2'd1,	// done, data valid
		OK_HOLD		= 2'd2,	// busy
		OK_FAULT	= 2'd3	// failed, code in data[15:0]
	} memOk;

	// cpu side data request
	typedef enum logic [1:0]
	{
		DC_NONE		= 2'd0,
		DC_LOAD		= 2'd1,
		DC_STORE	= 2'd2
	} dcOpm;

	// registered exception word
	typedef struct packed
	{
		logic [15:0]	pad;	// always zero
		logic [31:0]	addr;	// faulting byte address
		logic [15:0]	code;	// bit 15 marks critical
	} excWord;

endpackage

`default_nettype wire

/* design/memL1_cfg.svh */
`ifndef MEML1_CFG_SVH
`define MEML1_CFG_SVH

// byte address width on both the cpu side and the memory bus
`define L1_ADDR_BITS	32

// one cache line, also the width of the memory data bus
`define L1_LINE_BITS	128

// direct mapped, one line per set
`define L1_IC_LINES		64	// instruction cache sets
`define L1_DC_LINES		64	// data cache sets

// raised by the data cache when addr bits 1:0 are nonzero
// bit 15 set so it always counts as critical
`define L1_EXC_MISALIGN	16'h8001

`endif
